//--- kd_best_reader.sv
`timescale 1ns/100ps

module kd_best_reader (
    input  logic                    clk,
    input  logic                    rst_n,
    kd_step_if.reader               step,
    input  logic                    out_fifo_wfull_n,
    output logic                    out_fifo_wenq,
    output logic [3:0]              best_arr_csb1,
    output kd_main_pkg::best_addr_t best_arr_addr1
);
    import kd_main_pkg::*;

    logic rd_en;

    // one read in flight at a time, and only with room in the fifo
    assign rd_en = (step.phase == phase_readout) && !out_fifo_wenq && out_fifo_wfull_n;

    assign step.rd_beat = rd_en;

    // only the nearest entry is read
    assign best_arr_csb1  = rd_en ? 4'b1110 : 4'b1111;
    assign best_arr_addr1 = rd_en ? step.idx[$bits(best_addr_t)-1:0] : '0;

    // read data arrives next cycle, enqueue then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_fifo_wenq <= 1'b0;
        end else begin
            out_fifo_wenq <= step.beat && (step.phase == phase_readout);
        end
    end

    a_read_then_enq: assert property (@(posedge clk) disable iff (!rst_n)
        !(&best_arr_csb1) |=> out_fifo_wenq && (&best_arr_csb1));

endmodule

//--- kd_load_writer.sv
`timescale 1ns/100ps

module kd_load_writer (
    input  logic                     clk,
    input  logic                     rst_n,
    kd_step_if.writer                step,
    output logic                     int_node_fsm_enable,
    output kd_main_pkg::bank_sel_t   leaf_mem_csb0,
    output kd_main_pkg::bank_sel_t   leaf_mem_web0,
    output kd_main_pkg::leaf_addr_t  leaf_mem_addr0,
    output logic                     qp_mem_csb0,
    output logic                     qp_mem_web0,
    output kd_main_pkg::query_addr_t qp_mem_addr0
);
    import kd_main_pkg::*;

    localparam int BANK_W = $clog2($bits(bank_sel_t));

    bank_sel_t bank_sel;
    logic      leaf_wr;
    logic      query_wr;

    // node loader listens for the whole phase
    assign int_node_fsm_enable = (step.phase == phase_nodes);

    // binary to one-hot, active low
    always_comb begin
        bank_sel = '1;
        bank_sel[step.idx[BANK_W-1:0]] = 1'b0;
    end

    assign leaf_wr  = step.beat && (step.phase == phase_leaves);
    assign query_wr = step.beat && (step.phase == phase_querys);

    assign leaf_mem_csb0  = leaf_wr ? bank_sel : '1;
    assign leaf_mem_web0  = leaf_wr ? bank_sel : '1;
    // low bits pick the bank, the rest is the row
    assign leaf_mem_addr0 = leaf_wr ? step.idx[$bits(leaf_addr_t)+BANK_W-1:BANK_W] : '0;

    assign qp_mem_csb0  = !query_wr;
    assign qp_mem_web0  = !query_wr;
    assign qp_mem_addr0 = query_wr ? step.idx[$bits(query_addr_t)-1:0] : '0;

    a_one_bank: assert property (@(posedge clk) disable iff (!rst_n)
        (leaf_mem_csb0 != '1) |-> $onehot(~leaf_mem_csb0) && step.beat);

endmodule

//--- kd_main.f
+incdir+.
kd_main_pkg.sv
kd_step_if.sv
kd_seq_ctrl.sv
kd_load_writer.sv
kd_best_reader.sv
kd_main_top.sv
kd_main_tb.sv

//--- kd_main_defs.svh
`ifndef KD_MAIN_DEFS_SVH
`define KD_MAIN_DEFS_SVH

// k-d tree shape
`define KD_NUM_LEAVES 64
`define KD_NUM_NODES  63
// number of leaf memory banks
`define KD_LEAF_SIZE  8

// query grid
`define KD_ROW_SIZE   26
`define KD_COL_SIZE   19
`define KD_NUM_QUERYS (`KD_ROW_SIZE * `KD_COL_SIZE)

// aggregator fetch widths per load phase
`define KD_FW_NODES   1
`define KD_FW_LEAVES  5
`define KD_FW_QUERYS  4

`define KD_CNT_W      16

`endif

//--- kd_main_pkg.sv
`include "kd_main_defs.svh"

package kd_main_pkg;

    typedef enum logic [2:0] {
        phase_idle,
        phase_nodes,
        phase_leaves,
        phase_querys,
        phase_readout
    } kd_phase_e;

    typedef logic [`KD_CNT_W-1:0] cnt_t;

    typedef logic [$clog2(`KD_NUM_LEAVES)-1:0] leaf_addr_t;

    // one strobe per leaf bank, active low
    typedef logic [`KD_LEAF_SIZE-1:0] bank_sel_t;

    typedef logic [$clog2(`KD_NUM_QUERYS)-1:0] query_addr_t;

    // best array holds one entry per query
    typedef logic [$clog2(`KD_NUM_QUERYS)-1:0] best_addr_t;

    typedef logic [2:0] fetch_width_t;

endpackage

//--- kd_main_tb.sv
`timescale 1ns/100ps
`include "kd_main_defs.svh"

module kd_main_tb;
    import kd_main_pkg::*;

    // two loads and two readouts with random stalls, plus reset
    localparam int MAX_CYCLES = 8000;
    localparam int LEAF_WORDS = `KD_NUM_LEAVES * `KD_LEAF_SIZE;

    logic         clk;
    logic         rst_n;
    logic         load_kdtree;
    logic         send_best_arr;
    logic         agg_receiver_enq;
    logic         agg_receiver_full_n;
    logic         agg_change_fetch_width;
    fetch_width_t agg_input_fetch_width;
    logic         int_node_fsm_enable;
    bank_sel_t    leaf_mem_csb0;
    bank_sel_t    leaf_mem_web0;
    leaf_addr_t   leaf_mem_addr0;
    logic         qp_mem_csb0;
    logic         qp_mem_web0;
    query_addr_t  qp_mem_addr0;
    logic [3:0]   best_arr_csb1;
    best_addr_t   best_arr_addr1;
    logic         out_fifo_wenq;
    logic         out_fifo_wfull_n;

    int unsigned lcg_state = 73;
    int          cycle_cnt = 0;
    int          check_cnt = 0;
    int          err_cnt = 0;

    kd_main_top u_kd_main_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input logic bad);
        check_cnt++;
        if (bad) begin
            err_cnt++;
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_value(name, 32'(got), 32'(exp), got !== exp);
    endtask

    task automatic check_bank(input string name, input bank_sel_t got, input bank_sel_t exp);
        check_value(name, 32'(got), 32'(exp), got !== exp);
    endtask

    task automatic check_leaf_addr(input string name, input leaf_addr_t got, input leaf_addr_t exp);
        check_value(name, 32'(got), 32'(exp), got !== exp);
    endtask

    task automatic check_query_addr(input string name, input query_addr_t got,
                                    input query_addr_t exp);
        check_value(name, 32'(got), 32'(exp), got !== exp);
    endtask

    task automatic check_best_addr(input string name, input best_addr_t got, input best_addr_t exp);
        check_value(name, 32'(got), 32'(exp), got !== exp);
    endtask

    task automatic check_width(input string name, input fetch_width_t got,
                               input fetch_width_t exp);
        check_value(name, 32'(got), 32'(exp), got !== exp);
    endtask

    task automatic check_idle();
        check_bit("agg_receiver_full_n", agg_receiver_full_n, 1'b0);
        check_bit("agg_change_fetch_width", agg_change_fetch_width, 1'b0);
        check_bit("int_node_fsm_enable", int_node_fsm_enable, 1'b0);
        check_bank("leaf_mem_csb0", leaf_mem_csb0, '1);
        check_bank("leaf_mem_web0", leaf_mem_web0, '1);
        check_bit("qp_mem_csb0", qp_mem_csb0, 1'b1);
        check_bit("qp_mem_web0", qp_mem_web0, 1'b1);
        check_bit("&best_arr_csb1", &best_arr_csb1, 1'b1);
        check_bit("out_fifo_wenq", out_fifo_wenq, 1'b0);
    endtask

    // stages 0, 1, 2 are nodes, leaves and query patches
    task automatic run_load(input string name);
        int        errs;
        int        n;
        int        stage;
        int        last_idx;
        logic      enq;
        logic      last;
        bank_sel_t exp_bank;
        errs = err_cnt;
        @(negedge clk);
        load_kdtree = 1'b1;
        #25;
        check_bit("agg_change_fetch_width", agg_change_fetch_width, 1'b1);
        check_width("agg_input_fetch_width", agg_input_fetch_width, `KD_FW_NODES);
        n = 0;
        stage = 0;
        while (stage < 3) begin
            @(negedge clk);
            load_kdtree = 1'b0;
            enq = (lcg_next() % 4) != 0;
            agg_receiver_enq = enq;
            #25;
            last_idx = (stage == 0) ? `KD_NUM_NODES - 1 :
                       (stage == 1) ? LEAF_WORDS - 1 : `KD_NUM_QUERYS - 1;
            last = enq && (n == last_idx);
            exp_bank = (enq && stage == 1) ? ~bank_sel_t'(1 << (n % `KD_LEAF_SIZE)) : '1;
            check_bit("agg_receiver_full_n", agg_receiver_full_n, 1'b1);
            check_bit("int_node_fsm_enable", int_node_fsm_enable, stage == 0);
            check_bank("leaf_mem_csb0", leaf_mem_csb0, exp_bank);
            check_bank("leaf_mem_web0", leaf_mem_web0, exp_bank);
            if (enq && stage == 1) begin
                check_leaf_addr("leaf_mem_addr0", leaf_mem_addr0, leaf_addr_t'(n / 8));
            end
            check_bit("qp_mem_csb0", qp_mem_csb0, !(enq && stage == 2));
            check_bit("qp_mem_web0", qp_mem_web0, !(enq && stage == 2));
            if (enq && stage == 2) begin
                check_query_addr("qp_mem_addr0", qp_mem_addr0, query_addr_t'(n));
            end
            // width changes on the last node and last leaf word only
            check_bit("agg_change_fetch_width", agg_change_fetch_width, last && stage < 2);
            if (last && stage < 2) begin
                check_width("agg_input_fetch_width", agg_input_fetch_width,
                            (stage == 0) ? `KD_FW_LEAVES : `KD_FW_QUERYS);
            end
            n = enq ? n + 1 : n;
            if (last) begin
                stage++;
                n = 0;
            end
        end
        @(negedge clk);
        agg_receiver_enq = 1'b0;
        #25;
        check_idle();
        $display("test %s finished with %0d errors", name, err_cnt - errs);
    endtask

    task automatic run_readout(input string name, input logic with_load);
        int   errs;
        int   reads;
        int   enqs;
        logic rd_exp;
        logic wenq_exp;
        errs = err_cnt;
        @(negedge clk);
        send_best_arr = 1'b1;
        load_kdtree = with_load;
        #25;
        check_bit("agg_change_fetch_width", agg_change_fetch_width, 1'b0);
        reads = 0;
        enqs = 0;
        wenq_exp = 1'b0;
        while (enqs < `KD_NUM_QUERYS) begin
            @(negedge clk);
            send_best_arr = 1'b0;
            load_kdtree = 1'b0;
            out_fifo_wfull_n = (lcg_next() % 4) != 0;
            #25;
            rd_exp = (reads < `KD_NUM_QUERYS) && !wenq_exp && out_fifo_wfull_n;
            check_bit("out_fifo_wenq", out_fifo_wenq, wenq_exp);
            check_bit("best_arr_csb1[0]", best_arr_csb1[0], !rd_exp);
            check_bit("&best_arr_csb1[3:1]", &best_arr_csb1[3:1], 1'b1);
            if (rd_exp) begin
                check_best_addr("best_arr_addr1", best_arr_addr1, best_addr_t'(reads));
            end
            check_bit("agg_receiver_full_n", agg_receiver_full_n, 1'b0);
            check_bit("agg_change_fetch_width", agg_change_fetch_width, 1'b0);
            enqs = out_fifo_wenq ? enqs + 1 : enqs;
            reads = rd_exp ? reads + 1 : reads;
            wenq_exp = rd_exp;
        end
        @(negedge clk);
        out_fifo_wfull_n = 1'b1;
        #25;
        check_idle();
        $display("test %s finished with %0d errors", name, err_cnt - errs);
    endtask

    initial begin
        rst_n = 1'b0;
        load_kdtree = 1'b0;
        send_best_arr = 1'b0;
        agg_receiver_enq = 1'b0;
        out_fifo_wfull_n = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        #25;
        check_idle();
        $display("test reset_defaults finished with %0d errors", err_cnt);
        run_load("tree_load_and_fetch_width");
        run_readout("readout_back_pressure", 1'b0);
        run_readout("idle_priority", 1'b1);
        run_load("load_after_readout");
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- kd_main_top.sv
`timescale 1ns/100ps

module kd_main_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_kdtree,
    input  logic                      send_best_arr,

    input  logic                      agg_receiver_enq,
    output logic                      agg_receiver_full_n,
    output logic                      agg_change_fetch_width,
    output kd_main_pkg::fetch_width_t agg_input_fetch_width,

    output logic                      int_node_fsm_enable,

    output kd_main_pkg::bank_sel_t    leaf_mem_csb0,
    output kd_main_pkg::bank_sel_t    leaf_mem_web0,
    output kd_main_pkg::leaf_addr_t   leaf_mem_addr0,

    output logic                      qp_mem_csb0,
    output logic                      qp_mem_web0,
    output kd_main_pkg::query_addr_t  qp_mem_addr0,

    output logic [3:0]                best_arr_csb1,
    output kd_main_pkg::best_addr_t   best_arr_addr1,

    output logic                      out_fifo_wenq,
    input  logic                      out_fifo_wfull_n
);

    kd_step_if step ();

    kd_seq_ctrl u_kd_seq_ctrl (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .load_kdtree            (load_kdtree),
        .send_best_arr          (send_best_arr),
        .agg_receiver_enq       (agg_receiver_enq),
        .agg_receiver_full_n    (agg_receiver_full_n),
        .agg_change_fetch_width (agg_change_fetch_width),
        .agg_input_fetch_width  (agg_input_fetch_width),
        .step                   (step.seq)
    );

    kd_load_writer u_kd_load_writer (
        .clk                 (clk),
        .rst_n               (rst_n),
        .step                (step.writer),
        .int_node_fsm_enable (int_node_fsm_enable),
        .leaf_mem_csb0       (leaf_mem_csb0),
        .leaf_mem_web0       (leaf_mem_web0),
        .leaf_mem_addr0      (leaf_mem_addr0),
        .qp_mem_csb0         (qp_mem_csb0),
        .qp_mem_web0         (qp_mem_web0),
        .qp_mem_addr0        (qp_mem_addr0)
    );

    kd_best_reader u_kd_best_reader (
        .clk              (clk),
        .rst_n            (rst_n),
        .step             (step.reader),
        .out_fifo_wfull_n (out_fifo_wfull_n),
        .out_fifo_wenq    (out_fifo_wenq),
        .best_arr_csb1    (best_arr_csb1),
        .best_arr_addr1   (best_arr_addr1)
    );

endmodule

//--- kd_seq_ctrl.sv
`timescale 1ns/100ps
`include "kd_main_defs.svh"

module kd_seq_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_kdtree,
    input  logic                      send_best_arr,
    input  logic                      agg_receiver_enq,
    output logic                      agg_receiver_full_n,
    output logic                      agg_change_fetch_width,
    output kd_main_pkg::fetch_width_t agg_input_fetch_width,
    kd_step_if.seq                    step
);
    import kd_main_pkg::*;

    kd_phase_e phase_q;
    kd_phase_e phase_d;
    cnt_t      cnt_q;
    cnt_t      term_cnt;
    logic      beat;
    logic      cnt_done;
    logic      load_phase;

    assign load_phase = (phase_q == phase_nodes) || (phase_q == phase_leaves) ||
                        (phase_q == phase_querys);

    // aggregator is always ready while loading
    assign agg_receiver_full_n = load_phase;

    always_comb begin
        unique case (phase_q)
            phase_nodes:   term_cnt = cnt_t'(`KD_NUM_NODES - 1);
            phase_leaves:  term_cnt = cnt_t'(`KD_NUM_LEAVES * `KD_LEAF_SIZE - 1);
            phase_querys:  term_cnt = cnt_t'(`KD_NUM_QUERYS - 1);
            phase_readout: term_cnt = cnt_t'(`KD_NUM_QUERYS - 1);
            default:       term_cnt = '0;
        endcase
    end

    assign cnt_done = (cnt_q == term_cnt);

    always_comb begin
        if (load_phase) begin
            beat = agg_receiver_enq;
        end else if (phase_q == phase_readout) begin
            beat = step.rd_beat;
        end else begin
            beat = 1'b0;
        end
    end

    always_comb begin
        phase_d                = phase_q;
        agg_change_fetch_width = 1'b0;
        agg_input_fetch_width  = '0;

        unique case (phase_q)
            phase_idle: begin
                // readout has priority over a new load
                if (send_best_arr) begin
                    phase_d = phase_readout;
                end else if (load_kdtree) begin
                    phase_d                = phase_nodes;
                    agg_change_fetch_width = 1'b1;
                    agg_input_fetch_width  = fetch_width_t'(`KD_FW_NODES);
                end
            end
            phase_nodes: begin
                if (beat && cnt_done) begin
                    phase_d                = phase_leaves;
                    agg_change_fetch_width = 1'b1;
                    agg_input_fetch_width  = fetch_width_t'(`KD_FW_LEAVES);
                end
            end
            phase_leaves: begin
                if (beat && cnt_done) begin
                    phase_d                = phase_querys;
                    agg_change_fetch_width = 1'b1;
                    agg_input_fetch_width  = fetch_width_t'(`KD_FW_QUERYS);
                end
            end
            phase_querys, phase_readout: begin
                if (beat && cnt_done) begin
                    phase_d = phase_idle;
                end
            end
            default: phase_d = phase_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= phase_idle;
        end else begin
            phase_q <= phase_d;
        end
    end

    // beat ordinal within the phase, wraps at the terminal count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (beat) begin
            if (cnt_done) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign step.phase = phase_q;
    assign step.beat  = beat;
    assign step.idx   = cnt_q;

    // a load always opens with the node fetch-width pulse
    a_load_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(agg_receiver_full_n) |->
            $past(agg_change_fetch_width) &&
            ($past(agg_input_fetch_width) == fetch_width_t'(`KD_FW_NODES)));

endmodule

//--- kd_step_if.sv
`timescale 1ns/100ps

interface kd_step_if;
    import kd_main_pkg::*;

    kd_phase_e phase;
    // one word or entry handled this cycle
    logic      beat;
    cnt_t      idx;
    // readout request from the best-array reader
    logic      rd_beat;

    modport seq (
        output phase,
        output beat,
        output idx,
        input  rd_beat
    );

    modport writer (
        input phase,
        input beat,
        input idx
    );

    modport reader (
        input  phase,
        input  beat,
        input  idx,
        output rd_beat
    );

endinterface

//--- run_sim.sh
#!/bin/sh
# build and run the k-d tree controller testbench with Verilator

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f kd_main.f \
        --top-module kd_main_tb -o kd_main_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/kd_main_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
